//--- list.f
+incdir+logic
logic/axil_pkg.sv
logic/axil_slave_fsm.sv
logic/axil_reg_bank.sv
logic/axil_reg_top.sv
verif/axil_tb.sv

//--- logic/axil_config.svh
////////////////////
// AXI4-Lite register slave configuration
// Bus widths, register count and identification word
////////////////////

`ifndef AXIL_CONFIG_SVH
`define AXIL_CONFIG_SVH

// Byte address width seen on AW and AR
`define AXIL_ADDR_WIDTH 12

// Data bus width in bits
`define AXIL_DATA_WIDTH 32

// One strobe bit per data byte
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// Number of 32-bit registers in the bank, offsets 0x00 to 0x3C
`define AXIL_NUM_REGS 16

// Read-only identification word held in register 0
`define AXIL_ID_VALUE 32'hA5C1_0001

`endif

//--- logic/axil_pkg.sv
////////////////////
// AXI4-Lite register slave types
// Response codes, engine states and channel payloads
////////////////////

`include "axil_config.svh"

package axil_pkg;

  ////////////////////
  // Enumerations
  ////////////////////

  // Response encoding as carried on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Protocol engine states
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    // One of AW or W has arrived and is held
    WR_GATHER = 2'd1,
    WR_RESP   = 2'd2,
    RD_RESP   = 2'd3
  } axil_state_e;

  ////////////////////
  // Channel payloads
  ////////////////////

  // Write address channel
  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
  } axil_aw_t;

  // Write data channel
  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic [`AXIL_STRB_WIDTH-1:0] strb;
  } axil_w_t;

  // Read address channel
  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
  } axil_ar_t;

  // Read data channel
  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] data;
    axil_resp_e                  resp;
  } axil_r_t;

  // Write response channel
  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  // Committed write handed from the engine to the bank
  // 12 + 32 + 4 = 48 bits
  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic [`AXIL_STRB_WIDTH-1:0] strb;
  } axil_wr_req_t;

endpackage

//--- logic/axil_reg_bank.sv
////////////////////
// AXI4-Lite control register bank
// Word decode, byte-strobe merge and error detection
////////////////////

`timescale 1ns/1ps
`include "axil_config.svh"

module axil_reg_bank (
  input  logic                        ACLK,
  input  logic                        ARESETN,

  // Write port pulsed once per committed write
  input  logic                        wr_en,
  input  axil_pkg::axil_wr_req_t      wr_req,
  output logic                        wr_err,

  // Read port answered in the same cycle
  input  logic [`AXIL_ADDR_WIDTH-1:0] rd_addr,
  output logic [`AXIL_DATA_WIDTH-1:0] rd_data,
  output logic                        rd_err
);

  ////////////////////
  // Declarations
  ////////////////////

  // Bits needed to select one of the mapped registers
  localparam int IDX_W = $clog2(`AXIL_NUM_REGS);

  // Register storage with the identification word in entry 0
  logic [`AXIL_DATA_WIDTH-1:0] regs [`AXIL_NUM_REGS];

  // Word indexes drop the low two address bits
  logic [`AXIL_ADDR_WIDTH-3:0] wr_idx;
  logic [`AXIL_ADDR_WIDTH-3:0] rd_idx;

  // Index is inside the mapped range
  logic wr_hit;
  logic rd_hit;

  ////////////////////
  // Address decode
  ////////////////////

  assign wr_idx = wr_req.addr[`AXIL_ADDR_WIDTH-1:2];
  assign rd_idx = rd_addr[`AXIL_ADDR_WIDTH-1:2];

  assign wr_hit = (wr_idx < `AXIL_NUM_REGS);
  assign rd_hit = (rd_idx < `AXIL_NUM_REGS);

  // Writes refused outside the bank and on the ID word
  assign wr_err = !wr_hit || (wr_idx == '0);
  assign rd_err = !rd_hit;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      // ID word loads its constant and all others clear
      for (int i = 0; i < `AXIL_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      regs[0] <= `AXIL_ID_VALUE;
    end else if (wr_en && !wr_err) begin
      // Only strobed byte lanes change
      for (int j = 0; j < `AXIL_STRB_WIDTH; j++) begin
        if (wr_req.strb[j]) begin
          regs[wr_idx[IDX_W-1:0]][8*j +: 8] <= wr_req.data[8*j +: 8];
        end
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    if (!rd_hit) begin
      // Unmapped offsets read as zero
      rd_data = '0;
    end else begin
      // Entry 0 returns the stored ID word
      rd_data = regs[rd_idx[IDX_W-1:0]];
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // ID storage keeps its reset value whatever the bus writes
  a_id_const: assert property (@(posedge ACLK) disable iff (!ARESETN)
    $past(ARESETN) |-> (regs[0] == `AXIL_ID_VALUE));

endmodule

//--- logic/axil_reg_top.sv
////////////////////
// AXI4-Lite register slave top
// Protocol engine in front of the register bank
////////////////////

`timescale 1ns/1ps
`include "axil_config.svh"

module axil_reg_top (
  input  logic                   ACLK,
  input  logic                   ARESETN,

  // Write address channel
  input  axil_pkg::axil_aw_t     aw,
  input  logic                   aw_valid,
  output logic                   aw_ready,

  // Write data channel
  input  axil_pkg::axil_w_t      w,
  input  logic                   w_valid,
  output logic                   w_ready,

  // Read address channel
  input  axil_pkg::axil_ar_t     ar,
  input  logic                   ar_valid,
  output logic                   ar_ready,

  // Read data channel
  output axil_pkg::axil_r_t      r,
  output logic                   r_valid,
  input  logic                   r_ready,

  // Write response channel
  output axil_pkg::axil_b_t      b,
  output logic                   b_valid,
  input  logic                   b_ready
);

  ////////////////////
  // Engine to bank wiring
  ////////////////////

  logic                        wr_en;
  axil_pkg::axil_wr_req_t      wr_req;
  logic                        wr_err;
  logic [`AXIL_ADDR_WIDTH-1:0] rd_addr;
  logic [`AXIL_DATA_WIDTH-1:0] rd_data;
  logic                        rd_err;

  // Channel sequencing and response registers
  axil_slave_fsm i_axil_slave_fsm (
    .ACLK     (ACLK),
    .ARESETN  (ARESETN),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .wr_en    (wr_en),
    .wr_req   (wr_req),
    .wr_err   (wr_err),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_err   (rd_err)
  );

  // Control registers and error decode
  axil_reg_bank i_axil_reg_bank (
    .ACLK    (ACLK),
    .ARESETN (ARESETN),
    .wr_en   (wr_en),
    .wr_req  (wr_req),
    .wr_err  (wr_err),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_err  (rd_err)
  );

endmodule

//--- logic/axil_slave_fsm.sv
////////////////////
// AXI4-Lite protocol engine
// Sequences the five channels and registers the responses
////////////////////

`timescale 1ns/1ps
`include "axil_config.svh"

module axil_slave_fsm (
  input  logic                        ACLK,
  input  logic                        ARESETN,

  // Write address channel
  input  axil_pkg::axil_aw_t          aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,

  // Write data channel
  input  axil_pkg::axil_w_t           w,
  input  logic                        w_valid,
  output logic                        w_ready,

  // Read address channel
  input  axil_pkg::axil_ar_t          ar,
  input  logic                        ar_valid,
  output logic                        ar_ready,

  // Read data channel
  output axil_pkg::axil_r_t           r,
  output logic                        r_valid,
  input  logic                        r_ready,

  // Write response channel
  output axil_pkg::axil_b_t           b,
  output logic                        b_valid,
  input  logic                        b_ready,

  // Register bank side
  output logic                        wr_en,
  output axil_pkg::axil_wr_req_t      wr_req,
  input  logic                        wr_err,
  output logic [`AXIL_ADDR_WIDTH-1:0] rd_addr,
  input  logic [`AXIL_DATA_WIDTH-1:0] rd_data,
  input  logic                        rd_err
);

  ////////////////////
  // Declarations
  ////////////////////

  axil_pkg::axil_state_e state;
  axil_pkg::axil_state_e next_state;

  // Beat that arrived alone and waits for its partner
  axil_pkg::axil_aw_t aw_hold;
  axil_pkg::axil_w_t  w_hold;
  // High when the held beat is the address, low when it is the data
  logic               have_aw;

  // Channel handshakes
  logic aw_hs;
  logic w_hs;
  logic ar_hs;

  ////////////////////
  // Ready generation
  ////////////////////

  always_comb begin
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    ar_ready = 1'b0;
    case (state)
      axil_pkg::IDLE: begin
        aw_ready = 1'b1;
        w_ready  = 1'b1;
        // Writes win, so a read waits while any write beat is offered
        ar_ready = !aw_valid && !w_valid;
      end
      axil_pkg::WR_GATHER: begin
        // Only the missing half of the write is accepted
        aw_ready = !have_aw;
        w_ready  = have_aw;
      end
      default: begin
      end
    endcase
  end

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign ar_hs = ar_valid && ar_ready;

  // Response valids follow the state register directly
  assign b_valid = (state == axil_pkg::WR_RESP);
  assign r_valid = (state == axil_pkg::RD_RESP);

  ////////////////////
  // Write commit
  ////////////////////

  // Commit on the edge where the later of AW and W completes
  always_comb begin
    wr_en = 1'b0;
    if (state == axil_pkg::IDLE) begin
      wr_en = aw_hs && w_hs;
    end else if (state == axil_pkg::WR_GATHER) begin
      wr_en = have_aw ? w_hs : aw_hs;
    end
  end

  // Merge held and live beats into one request
  always_comb begin
    if ((state == axil_pkg::WR_GATHER) && have_aw) begin
      wr_req.addr = aw_hold.addr;
    end else begin
      wr_req.addr = aw.addr;
    end
    if ((state == axil_pkg::WR_GATHER) && !have_aw) begin
      wr_req.data = w_hold.data;
      wr_req.strb = w_hold.strb;
    end else begin
      wr_req.data = w.data;
      wr_req.strb = w.strb;
    end
  end

  // Bank read port looks straight at the AR payload
  assign rd_addr = ar.addr;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    next_state = state;
    case (state)
      axil_pkg::IDLE: begin
        if (aw_hs && w_hs) begin
          next_state = axil_pkg::WR_RESP;
        end else if (aw_hs || w_hs) begin
          next_state = axil_pkg::WR_GATHER;
        end else if (ar_hs) begin
          next_state = axil_pkg::RD_RESP;
        end
      end
      axil_pkg::WR_GATHER: begin
        if (wr_en) begin
          next_state = axil_pkg::WR_RESP;
        end
      end
      axil_pkg::WR_RESP: begin
        if (b_ready) begin
          next_state = axil_pkg::IDLE;
        end
      end
      axil_pkg::RD_RESP: begin
        if (r_ready) begin
          next_state = axil_pkg::IDLE;
        end
      end
      default: begin
        next_state = axil_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      state <= axil_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Remember which half of the write was captured first
  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      have_aw <= 1'b0;
    end else if (state == axil_pkg::IDLE) begin
      have_aw <= aw_hs;
    end
  end

  ////////////////////
  // Holding and response registers
  ////////////////////

  always_ff @(posedge ACLK) begin
    if ((state == axil_pkg::IDLE) && aw_hs && !w_hs) begin
      aw_hold <= aw;
    end
    if ((state == axil_pkg::IDLE) && w_hs && !aw_hs) begin
      w_hold <= w;
    end
  end

  // Error status is decided by the bank and copied here
  always_ff @(posedge ACLK) begin
    if (wr_en) begin
      b.resp <= wr_err ? axil_pkg::SLVERR : axil_pkg::OKAY;
    end
    if (ar_hs) begin
      r.data <= rd_data;
      r.resp <= rd_err ? axil_pkg::SLVERR : axil_pkg::OKAY;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // A commit lasts exactly one cycle
  a_wr_pulse: assert property (@(posedge ACLK) disable iff (!ARESETN)
    wr_en |=> !wr_en);

  // Stalled responses keep valid and payload
  a_b_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
    (b_valid && !b_ready) |=> (b_valid && $stable(b)));

  a_r_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
    (r_valid && !r_ready) |=> (r_valid && $stable(r)));

endmodule

//--- verif/axil_tb.sv
////////////////////
// AXI4-Lite register slave testbench
// Bus master tasks against a reference register model
////////////////////

`timescale 1ns/1ps
`include "axil_config.svh"

module axil_tb;

  // Cycles allowed for any single handshake
  localparam int TIMEOUT = 100;

  logic                   ACLK;
  logic                   ARESETN;
  axil_pkg::axil_aw_t     aw;
  logic                   aw_valid;
  logic                   aw_ready;
  axil_pkg::axil_w_t      w;
  logic                   w_valid;
  logic                   w_ready;
  axil_pkg::axil_ar_t     ar;
  logic                   ar_valid;
  logic                   ar_ready;
  axil_pkg::axil_r_t      r;
  logic                   r_valid;
  logic                   r_ready;
  axil_pkg::axil_b_t      b;
  logic                   b_valid;
  logic                   b_ready;

  // Expected register contents, entry 0 unused
  logic [`AXIL_DATA_WIDTH-1:0] model [`AXIL_NUM_REGS];
  int seed = 25;
  int value_errors = 0;
  int timeout_errors = 0;

  axil_reg_top i_axil_reg_top (
    .ACLK (ACLK), .ARESETN (ARESETN),
    .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w (w), .w_valid (w_valid), .w_ready (w_ready),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready)
  );

  always #5 ACLK = ~ACLK;

  ////////////////////
  // Reference model
  ////////////////////

  // Bank rules, write updates the model, read returns the expected word
  function automatic axil_pkg::axil_r_t ref_access(input logic is_wr,
      input logic [`AXIL_ADDR_WIDTH-1:0] addr, input logic [`AXIL_DATA_WIDTH-1:0] data,
      input logic [`AXIL_STRB_WIDTH-1:0] strb);
    int idx;
    axil_pkg::axil_r_t res;
    idx = addr[`AXIL_ADDR_WIDTH-1:2];
    res.data = '0;
    res.resp = axil_pkg::OKAY;
    if (idx >= `AXIL_NUM_REGS) begin
      res.resp = axil_pkg::SLVERR;
    end else if (is_wr) begin
      // ID word refuses writes
      if (idx == 0) begin
        res.resp = axil_pkg::SLVERR;
      end else begin
        for (int j = 0; j < `AXIL_STRB_WIDTH; j++) begin
          if (strb[j]) model[idx][8*j +: 8] = data[8*j +: 8];
        end
      end
    end else begin
      res.data = (idx == 0) ? `AXIL_ID_VALUE : model[idx];
    end
    return res;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_b(input string test, input axil_pkg::axil_b_t expected,
      input axil_pkg::axil_b_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %s: expected resp %h actual resp %h", test, expected, actual);
    end
  endtask

  task automatic check_r(input string test, input axil_pkg::axil_r_t expected,
      input axil_pkg::axil_r_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %s: expected data/resp %h actual data/resp %h", test, expected, actual);
    end
  endtask

  ////////////////////
  // Channel drivers
  ////////////////////

  // Ready is sampled just after the falling edge, when it is settled
  task automatic send_aw(input logic [`AXIL_ADDR_WIDTH-1:0] addr, input int delay);
    int n;
    repeat (delay) @(negedge ACLK);
    aw.addr = addr;
    aw_valid = 1'b1;
    n = 0;
    #1;
    while (!aw_ready && n < TIMEOUT) begin
      @(negedge ACLK);
      #1;
      n++;
    end
    if (!aw_ready) begin
      timeout_errors++;
      $display("Timeout: write address %h was never accepted", addr);
    end
    @(negedge ACLK);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [`AXIL_DATA_WIDTH-1:0] data,
      input logic [`AXIL_STRB_WIDTH-1:0] strb, input int delay);
    int n;
    repeat (delay) @(negedge ACLK);
    w.data = data;
    w.strb = strb;
    w_valid = 1'b1;
    n = 0;
    #1;
    while (!w_ready && n < TIMEOUT) begin
      @(negedge ACLK);
      #1;
      n++;
    end
    if (!w_ready) begin
      timeout_errors++;
      $display("Timeout: write data %h was never accepted", data);
    end
    @(negedge ACLK);
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
    int n;
    ar.addr = addr;
    ar_valid = 1'b1;
    n = 0;
    #1;
    while (!ar_ready && n < TIMEOUT) begin
      @(negedge ACLK);
      #1;
      n++;
    end
    if (!ar_ready) begin
      timeout_errors++;
      $display("Timeout: read address %h was never accepted", addr);
    end
    @(negedge ACLK);
    ar_valid = 1'b0;
  endtask

  // Random ready gaps while the response is pending
  task automatic take_b(output axil_pkg::axil_b_t got);
    int n;
    logic done;
    n = 0;
    done = 1'b0;
    got = 'x;
    while (!done && n < TIMEOUT) begin
      b_ready = $random(seed) & 1;
      #1;
      if (b_valid && b_ready) begin
        got = b;
        done = 1'b1;
      end
      @(negedge ACLK);
      n++;
    end
    b_ready = 1'b0;
    if (!done) begin
      timeout_errors++;
      $display("Timeout: no write response arrived");
    end
  endtask

  task automatic take_r(output axil_pkg::axil_r_t got);
    int n;
    logic done;
    n = 0;
    done = 1'b0;
    got = 'x;
    while (!done && n < TIMEOUT) begin
      r_ready = $random(seed) & 1;
      #1;
      if (r_valid && r_ready) begin
        got = r;
        done = 1'b1;
      end
      @(negedge ACLK);
      n++;
    end
    r_ready = 1'b0;
    if (!done) begin
      timeout_errors++;
      $display("Timeout: no read data arrived");
    end
  endtask

  ////////////////////
  // Bus master tasks
  ////////////////////

  // Delays set which of AW and W is offered first
  task automatic axil_write(input string test, input logic [`AXIL_ADDR_WIDTH-1:0] addr,
      input logic [`AXIL_DATA_WIDTH-1:0] data, input logic [`AXIL_STRB_WIDTH-1:0] strb,
      input int aw_first_delay, input int w_first_delay);
    axil_pkg::axil_r_t exp;
    axil_pkg::axil_b_t exp_b;
    axil_pkg::axil_b_t got_b;
    exp = ref_access(1'b1, addr, data, strb);
    exp_b.resp = exp.resp;
    @(negedge ACLK);
    fork
      send_aw(addr, aw_first_delay);
      send_w(data, strb, w_first_delay);
    join
    take_b(got_b);
    check_b(test, exp_b, got_b);
  endtask

  task automatic axil_read(input string test, input logic [`AXIL_ADDR_WIDTH-1:0] addr);
    axil_pkg::axil_r_t exp;
    axil_pkg::axil_r_t got;
    exp = ref_access(1'b0, addr, '0, '0);
    @(negedge ACLK);
    send_ar(addr);
    take_r(got);
    check_r(test, exp, got);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] data;
    ACLK = 1'b0;
    ARESETN = 1'b0;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    b_ready = 1'b0;
    for (int i = 0; i < `AXIL_NUM_REGS; i++) model[i] = '0;
    repeat (4) @(posedge ACLK);
    @(negedge ACLK);
    ARESETN = 1'b1;

    // Reset values, ID word at offset 0
    for (int i = 0; i < `AXIL_NUM_REGS; i++) axil_read("reset_read", 4 * i);

    // Full-strobe writes and readback
    for (int i = 1; i < `AXIL_NUM_REGS; i++) begin
      axil_write("full_write", 4 * i, $random(seed), 4'hF, 0, 0);
      axil_read("full_readback", 4 * i);
    end

    // Partial strobes, every pattern once
    for (int i = 1; i < `AXIL_NUM_REGS; i++) begin
      axil_write("strb_write", 4 * i, $random(seed), i, 0, 0);
      axil_read("strb_readback", 4 * i);
    end

    // ID word and unmapped offsets
    axil_write("id_write", 12'h000, 32'hFFFF_FFFF, 4'hF, 0, 0);
    axil_read("id_read", 12'h000);
    axil_write("unmapped_write", 12'h040, 32'h1234_5678, 4'hF, 0, 0);
    axil_write("unmapped_write_top", 12'hFFC, 32'h8765_4321, 4'hF, 0, 0);
    axil_read("unmapped_read", 12'h040);
    axil_read("unmapped_read_top", 12'hFFC);

    // AW first, W first, then both together
    axil_write("aw_first", 12'h014, 32'hDEAD_BEEF, 4'hF, 0, 3);
    axil_read("aw_first_readback", 12'h014);
    axil_write("w_first", 12'h018, 32'hCAFE_F00D, 4'h5, 3, 0);
    axil_read("w_first_readback", 12'h018);
    axil_write("aw_w_together", 12'h01C, 32'h0BAD_CAFE, 4'hA, 0, 0);
    axil_read("aw_w_together_readback", 12'h01C);

    // Random mix, half mapped and half anywhere in the address space
    for (int k = 0; k < 200; k++) begin
      addr = ($random(seed) & 1) ? ($random(seed) & 12'h03F) : ($random(seed) & 12'hFFF);
      data = $random(seed);
      if ($random(seed) & 1) begin
        axil_write("random_write", addr, data, $random(seed), $random(seed) & 3,
                   $random(seed) & 3);
      end else begin
        axil_read("random_read", addr);
      end
    end

    repeat (2) @(negedge ACLK);
    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
